/* source/bus_pkg.sv */
package bus_pkg;

    // Word address bits decoded by the RAM, covering byte address bits 19 to 1
    localparam int ADDR_WIDTH = 19;

    // One bus word and its byte lanes
    localparam int DATA_WIDTH = 16;
    localparam int BYTE_LANES = DATA_WIDTH / 8;

    // Wait cycles the RAM inserts before its acknowledge
    localparam int RAM_WAIT_STATES = 2;

    // Counter must reach RAM_WAIT_STATES - 1
    localparam int WAIT_CNT_WIDTH = $clog2(RAM_WAIT_STATES + 1);

    // One RAM word per word address
    localparam int RAM_DEPTH = 2 ** ADDR_WIDTH;

    typedef logic [ADDR_WIDTH-1:0] word_addr_t;
    typedef logic [DATA_WIDTH-1:0] bus_word_t;

    // Bit 0 selects the low byte, bit 1 the high byte
    typedef logic [BYTE_LANES-1:0] byte_sel_t;

endpackage

/* source/arb_pkg.sv */
package arb_pkg;

    // Arbiter FSM
    // PRESERVE holds the grant for one cycle before the shared access rises
    // SERVING waits for the memory acknowledge
    typedef enum logic [2:0] {
        IDLE,
        PRESERVE_INSTR,
        PRESERVE_DATA,
        SERVING_INSTR,
        SERVING_DATA
    } arb_state_t;

    // Bus masters seen by the arbiter
    typedef enum logic {
        MASTER_INSTR,
        MASTER_DATA
    } master_id_t;

endpackage

/* source/mem_bus_if.sv */
`timescale 1ns/1ps

interface mem_bus_if
    import bus_pkg::*;
();

    // Word address and write data, held steady until ack
    word_addr_t addr;
    bus_word_t  wdata;

    // Read data, valid in the ack cycle
    bus_word_t  rdata;

    // Access request and one-cycle acknowledge
    logic       access;
    logic       ack;

    // Write enable and byte lanes of the transaction
    logic       wr_en;
    byte_sel_t  bytesel;

    // Side that starts transactions
    modport requester (
        output addr, wdata, access, wr_en, bytesel,
        input  rdata, ack
    );

    // Side that answers them
    modport responder (
        input  addr, wdata, access, wr_en, bytesel,
        output rdata, ack
    );

endinterface

/* source/id_arbiter.sv */
`timescale 1ns/1ps

module id_arbiter
    import bus_pkg::*;
    import arb_pkg::*;
(
    input  logic         clk,
    input  logic         reset,

    // Instruction fetch master
    mem_bus_if.responder instr_bus,

    // Load/store master
    mem_bus_if.responder data_bus,

    // Shared memory port
    mem_bus_if.requester mem_bus,

    // High while a transaction is in flight
    output logic         busy
);

    arb_state_t state_q;

    // Round-robin history, the master not served last wins a tie
    master_id_t last_served_q;

    // Registered grant that steers the muxes
    master_id_t grant_q;

    // Registered shared access
    logic       mem_access_q;

    // IDLE decision
    logic       instr_wins;

    // Acks routed back to the masters
    logic       instr_ack;
    logic       data_ack;

    // Instruction wins when it asks and data is quiet or was served last
    assign instr_wins = instr_bus.access &&
                        (last_served_q == MASTER_DATA || !data_bus.access);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q       <= IDLE;
            last_served_q <= MASTER_DATA;
            grant_q       <= MASTER_INSTR;
            mem_access_q  <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    // Pick a master, grant is registered here and stays fixed
                    if (instr_wins) begin
                        state_q <= PRESERVE_INSTR;
                        grant_q <= MASTER_INSTR;
                    end else if (data_bus.access) begin
                        state_q <= PRESERVE_DATA;
                        grant_q <= MASTER_DATA;
                    end
                end

                PRESERVE_INSTR: begin
                    // Muxes have settled on the grant, now open the shared port
                    mem_access_q <= 1'b1;
                    state_q      <= SERVING_INSTR;
                end

                PRESERVE_DATA: begin
                    mem_access_q <= 1'b1;
                    state_q      <= SERVING_DATA;
                end

                SERVING_INSTR: begin
                    // Ack cycle ends here
                    if (mem_bus.ack) begin
                        mem_access_q  <= 1'b0;
                        last_served_q <= MASTER_INSTR;
                        state_q       <= IDLE;
                    end
                end

                SERVING_DATA: begin
                    if (mem_bus.ack) begin
                        mem_access_q  <= 1'b0;
                        last_served_q <= MASTER_DATA;
                        state_q       <= IDLE;
                    end
                end

                default: begin
                    mem_access_q <= 1'b0;
                    state_q      <= IDLE;
                end
            endcase
        end
    end

    // Busy from PRESERVE through the ack cycle
    assign busy = (state_q != IDLE);

    assign mem_bus.access = mem_access_q;

    // Request fields of the granted master
    always_comb begin
        if (grant_q == MASTER_INSTR) begin
            mem_bus.addr    = instr_bus.addr;
            mem_bus.wdata   = instr_bus.wdata;
            mem_bus.wr_en   = instr_bus.wr_en;
            mem_bus.bytesel = instr_bus.bytesel;
        end else begin
            mem_bus.addr    = data_bus.addr;
            mem_bus.wdata   = data_bus.wdata;
            mem_bus.wr_en   = data_bus.wr_en;
            mem_bus.bytesel = data_bus.bytesel;
        end
    end

    // Ack reaches only the granted master
    assign instr_ack = busy && (grant_q == MASTER_INSTR) && mem_bus.ack;
    assign data_ack  = busy && (grant_q == MASTER_DATA) && mem_bus.ack;

    assign instr_bus.ack = instr_ack;
    assign data_bus.ack  = data_ack;

    // Read word only in the served master's ack cycle, zero otherwise
    always_comb begin
        instr_bus.rdata = bus_word_t'(0);
        data_bus.rdata  = bus_word_t'(0);
        if (instr_ack) begin
            instr_bus.rdata = mem_bus.rdata;
        end
        if (data_ack) begin
            data_bus.rdata = mem_bus.rdata;
        end
    end

endmodule

/* source/word_ram.sv */
`timescale 1ns/1ps

module word_ram
    import bus_pkg::*;
(
    input  logic         clk,
    input  logic         reset,

    // Single port from the arbiter
    mem_bus_if.responder bus
);

    // Storage, one word per decoded address
    bus_word_t mem [RAM_DEPTH];

    // Wait-state counter
    logic [WAIT_CNT_WIDTH-1:0] wait_cnt_q;

    // Set once the current access has been acked
    logic done_q;

    // Registered acknowledge and read word
    logic      ack_q;
    bus_word_t rdata_q;

    // Last wait cycle of a pending access
    logic      ack_next;

    // Merged word for a lane write
    bus_word_t wr_word;

    assign ack_next = bus.access && !done_q &&
                      (wait_cnt_q == WAIT_CNT_WIDTH'(RAM_WAIT_STATES - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wait_cnt_q <= '0;
            done_q     <= 1'b0;
            ack_q      <= 1'b0;
        end else begin
            // Ack is a single pulse
            ack_q <= 1'b0;
            if (!bus.access) begin
                // Access has fallen, rearm for the next one
                wait_cnt_q <= '0;
                done_q     <= 1'b0;
            end else if (!done_q) begin
                if (ack_next) begin
                    ack_q      <= 1'b1;
                    done_q     <= 1'b1;
                    wait_cnt_q <= '0;
                end else begin
                    wait_cnt_q <= wait_cnt_q + 1'b1;
                end
            end
        end
    end

    // Old word with the selected lanes replaced
    always_comb begin
        wr_word = mem[bus.addr];
        if (bus.bytesel[0]) begin
            wr_word[7:0] = bus.wdata[7:0];
        end
        if (bus.bytesel[1]) begin
            wr_word[15:8] = bus.wdata[15:8];
        end
    end

    // Write and read capture at the edge that raises ack
    always_ff @(posedge clk) begin
        if (ack_next) begin
            if (bus.wr_en) begin
                mem[bus.addr] <= wr_word;
            end
            // Word before this access
            rdata_q <= mem[bus.addr];
        end
    end

    assign bus.ack   = ack_q;
    assign bus.rdata = rdata_q;

endmodule

/* source/mem_subsystem_top.sv */
`timescale 1ns/1ps

module mem_subsystem_top
    import bus_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    // Instruction fetch master
    input  word_addr_t instr_addr,
    input  bus_word_t  instr_wdata,
    input  logic       instr_access,
    input  logic       instr_wr_en,
    input  byte_sel_t  instr_bytesel,
    output bus_word_t  instr_rdata,
    output logic       instr_ack,

    // Load/store master
    input  word_addr_t data_addr,
    input  bus_word_t  data_wdata,
    input  logic       data_access,
    input  logic       data_wr_en,
    input  byte_sel_t  data_bytesel,
    output bus_word_t  data_rdata,
    output logic       data_ack,

    // Shared bus in use
    output logic       busy
);

    // Master buses into the arbiter and the shared bus to the RAM
    mem_bus_if instr_bus ();
    mem_bus_if data_bus ();
    mem_bus_if mem_bus ();

    // Instruction requester side from the ports
    assign instr_bus.addr    = instr_addr;
    assign instr_bus.wdata   = instr_wdata;
    assign instr_bus.access  = instr_access;
    assign instr_bus.wr_en   = instr_wr_en;
    assign instr_bus.bytesel = instr_bytesel;
    assign instr_rdata       = instr_bus.rdata;
    assign instr_ack         = instr_bus.ack;

    // Data requester side from the ports
    assign data_bus.addr    = data_addr;
    assign data_bus.wdata   = data_wdata;
    assign data_bus.access  = data_access;
    assign data_bus.wr_en   = data_wr_en;
    assign data_bus.bytesel = data_bytesel;
    assign data_rdata       = data_bus.rdata;
    assign data_ack         = data_bus.ack;

    // Round-robin between the two masters
    id_arbiter id_arbiter_i (
        .clk       (clk),
        .reset     (reset),
        .instr_bus (instr_bus),
        .data_bus  (data_bus),
        .mem_bus   (mem_bus),
        .busy      (busy)
    );

    // Memory target behind the arbiter
    word_ram word_ram_i (
        .clk   (clk),
        .reset (reset),
        .bus   (mem_bus)
    );

endmodule

/* sim/id_arbiter_properties.sv */
`timescale 1ns/1ps

module id_arbiter_properties
    import bus_pkg::*;
    import arb_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input logic       instr_access,
    input logic       instr_ack,
    input logic       data_access,
    input logic       data_ack,
    input logic       mem_access,
    input logic       busy,
    input arb_state_t state
);

    // Only the granted master is acked
    ack_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(instr_ack && data_ack)) else $error("both master acks high together");

    // No ack without a pending request
    instr_ack_access: assert property (@(posedge clk) disable iff (reset)
        instr_ack |-> instr_access) else $error("instruction ack without access");
    data_ack_access: assert property (@(posedge clk) disable iff (reset)
        data_ack |-> data_access) else $error("data ack without access");

    // Shared access only while serving
    mem_access_busy: assert property (@(posedge clk) disable iff (reset)
        mem_access |-> busy && (state == SERVING_INSTR || state == SERVING_DATA))
        else $error("memory access outside a serving state");

    mem_access_reset: assert property (@(posedge clk)
        reset |-> !mem_access) else $error("memory access high during reset");

endmodule

bind id_arbiter id_arbiter_properties id_arbiter_properties_i (
    .clk          (clk),
    .reset        (reset),
    .instr_access (instr_bus.access),
    .instr_ack    (instr_ack),
    .data_access  (data_bus.access),
    .data_ack     (data_ack),
    .mem_access   (mem_access_q),
    .busy         (busy),
    .state        (state_q)
);

/* sim/mem_subsystem_tb.sv */
`timescale 1ns/1ps

module mem_subsystem_tb
    import bus_pkg::*;
();

    // Cycles from driving access to the ack on an idle bus
    localparam int IDLE_LATENCY = 2 + RAM_WAIT_STATES;
    localparam int ACK_TIMEOUT = 50;
    localparam int RANDOM_OPS = 24;
    localparam int POOL_SIZE = 8;
    // Address window shared by both masters in the random traffic
    localparam word_addr_t POOL_BASE = 19'h2a5c0;
    // Directed, random and sweep accesses, each up to two transactions long
    localparam int TOTAL_OPS = 14 + RANDOM_OPS + POOL_SIZE;
    localparam int WATCHDOG_CYCLES = TOTAL_OPS * 2 * (IDLE_LATENCY + 3) + 200;

    logic       clk, reset, busy;
    word_addr_t instr_addr, data_addr;
    bus_word_t  instr_wdata, data_wdata, instr_rdata, data_rdata;
    logic       instr_access, data_access, instr_wr_en, data_wr_en;
    logic       instr_ack, data_ack;
    byte_sel_t  instr_bytesel, data_bytesel;

    // Expected RAM contents, written words only
    bus_word_t   ref_mem [word_addr_t];
    // Owner of each ack in order, 1 for the data master
    bit          ack_order [$];
    logic [15:0] lfsr_q;
    int          checks, errors;
    word_addr_t  instr_word_addr, data_word_addr;

    mem_subsystem_top mem_subsystem_top_i (.*);

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // Only the selected byte lanes take the new data
    function automatic bus_word_t lane_merge(input bus_word_t old, input bus_word_t wd,
                                             input byte_sel_t bs);
        lane_merge = old;
        if (bs[0]) lane_merge[7:0] = wd[7:0];
        if (bs[1]) lane_merge[15:8] = wd[15:8];
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    // One transaction, access stays high after the ack until the caller moves on
    task automatic xfer(input bit is_data, input bit wr, input word_addr_t a,
                        input bus_word_t wd, input byte_sel_t bs,
                        output bus_word_t rd, output int cycles);
        bit got_ack;
        @(posedge clk);
        #1;
        if (is_data) begin
            data_addr = a;
            data_wdata = wd;
            data_wr_en = wr;
            data_bytesel = bs;
            data_access = 1'b1;
        end else begin
            instr_addr = a;
            instr_wdata = wd;
            instr_wr_en = wr;
            instr_bytesel = bs;
            instr_access = 1'b1;
        end
        cycles = 0;
        got_ack = 1'b0;
        rd = '0;
        // Ack sampled mid-cycle, away from the edges
        while (!got_ack && cycles < ACK_TIMEOUT) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
            got_ack = is_data ? data_ack : instr_ack;
        end
        if (got_ack) begin
            rd = is_data ? data_rdata : instr_rdata;
            if (wr) begin
                ref_mem[a] = lane_merge(ref_mem.exists(a) ? ref_mem[a] : bus_word_t'(0), wd, bs);
            end
            ack_order.push_back(is_data);
        end else begin
            $display("the %s master got no acknowledge within %0d cycles",
                     is_data ? "data" : "instruction", ACK_TIMEOUT);
            errors++;
        end
    endtask

    task automatic drop_access(input bit is_data);
        @(posedge clk);
        #1;
        if (is_data) data_access = 1'b0;
        else instr_access = 1'b0;
    endtask

    task automatic access_once(input bit is_data, input bit wr, input word_addr_t a,
                               input bus_word_t wd, input byte_sel_t bs, output bus_word_t rd);
        int cycles;
        xfer(is_data, wr, a, wd, bs, rd, cycles);
        drop_access(is_data);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        $display("test %s %s", name, (errors == errors_before) ? "ok" : "failed");
    endtask

    task automatic write_read_idle();
        bus_word_t wd, rd;
        int cycles, e0;
        e0 = errors;
        instr_word_addr = word_addr_t'(take_bits(ADDR_WIDTH));
        wd = bus_word_t'(take_bits(DATA_WIDTH));
        xfer(1'b0, 1'b1, instr_word_addr, wd, 2'b11, rd, cycles);
        drop_access(1'b0);
        check("write ack latency", cycles, IDLE_LATENCY);
        xfer(1'b0, 1'b0, instr_word_addr, '0, 2'b11, rd, cycles);
        drop_access(1'b0);
        check("read ack latency", cycles, IDLE_LATENCY);
        check("instruction read word", 32'(rd), 32'(wd));
        finish_test("idle latency", e0);
    endtask

    task automatic byte_lane_writes();
        bus_word_t full, low, high, rd;
        int e0;
        e0 = errors;
        data_word_addr = word_addr_t'(take_bits(ADDR_WIDTH));
        full = bus_word_t'(take_bits(DATA_WIDTH));
        low = bus_word_t'(take_bits(DATA_WIDTH));
        high = bus_word_t'(take_bits(DATA_WIDTH));
        access_once(1'b1, 1'b1, data_word_addr, full, 2'b11, rd);
        access_once(1'b1, 1'b1, data_word_addr, low, 2'b01, rd);
        access_once(1'b1, 1'b0, data_word_addr, '0, 2'b11, rd);
        check("low lane write", 32'(rd), 32'({full[15:8], low[7:0]}));
        access_once(1'b1, 1'b1, data_word_addr, high, 2'b10, rd);
        access_once(1'b1, 1'b0, data_word_addr, '0, 2'b11, rd);
        check("high lane write", 32'(rd), 32'({high[15:8], low[7:0]}));
        finish_test("byte lanes", e0);
    endtask

    task automatic contended_round_robin();
        bus_word_t rd_i, rd_d;
        int c_i, c_d, e0;
        e0 = errors;
        apply_reset();
        ack_order.delete();
        // Both masters request together and keep requesting
        fork
            begin
                for (int i = 0; i < 3; i++) begin
                    xfer(1'b0, 1'b0, instr_word_addr, '0, 2'b11, rd_i, c_i);
                    check("contended instruction read", 32'(rd_i), 32'(ref_mem[instr_word_addr]));
                end
                drop_access(1'b0);
            end
            begin
                for (int i = 0; i < 3; i++) begin
                    xfer(1'b1, 1'b0, data_word_addr, '0, 2'b11, rd_d, c_d);
                    check("contended data read", 32'(rd_d), 32'(ref_mem[data_word_addr]));
                end
                drop_access(1'b1);
            end
        join
        check("ack count", ack_order.size(), 6);
        foreach (ack_order[i]) check("ack owner", 32'(ack_order[i]), i % 2);
        finish_test("round robin", e0);
    endtask

    task automatic idle_master_isolation();
        bus_word_t rd;
        int cycles, e0;
        bit seen;
        e0 = errors;
        fork
            xfer(1'b0, 1'b0, instr_word_addr, '0, 2'b11, rd, cycles);
            begin
                seen = 1'b0;
                for (int i = 0; i < ACK_TIMEOUT && !seen; i++) begin
                    @(negedge clk);
                    check("idle master ack", 32'(data_ack), 0);
                    check("idle master rdata", 32'(data_rdata), 0);
                    seen = instr_ack;
                end
                check("busy in the ack cycle", 32'(busy), 1);
            end
        join
        check("instruction read word", 32'(rd), 32'(ref_mem[instr_word_addr]));
        drop_access(1'b0);
        @(negedge clk);
        check("busy after the ack", 32'(busy), 0);
        finish_test("isolation", e0);
    endtask

    task automatic random_traffic();
        bus_word_t wd, rd;
        word_addr_t a;
        byte_sel_t bs;
        bit is_data, wr;
        int e0;
        e0 = errors;
        for (int n = 0; n < RANDOM_OPS + POOL_SIZE; n++) begin
            is_data = 1'(take_bits(1));
            a = POOL_BASE + word_addr_t'(take_bits($clog2(POOL_SIZE)));
            wr = 1'(take_bits(1));
            wd = bus_word_t'(take_bits(DATA_WIDTH));
            bs = byte_sel_t'(take_bits(BYTE_LANES));
            // First touch of a word is a full write, then reads have a known value
            if (!ref_mem.exists(a)) begin
                wr = 1'b1;
                bs = 2'b11;
            end
            // Closing sweep reads every pool word
            if (n >= RANDOM_OPS) begin
                a = POOL_BASE + word_addr_t'(n - RANDOM_OPS);
                wr = !ref_mem.exists(a);
            end
            access_once(is_data, wr, a, wd, bs, rd);
            if (!wr) check("random read", 32'(rd), 32'(ref_mem[a]));
        end
        finish_test("random traffic", e0);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout, the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        {instr_addr, instr_wdata, instr_access, instr_wr_en, instr_bytesel} = '0;
        {data_addr, data_wdata, data_access, data_wr_en, data_bytesel} = '0;
        lfsr_q = 16'd63;
        checks = 0;
        errors = 0;
        apply_reset();
        write_read_idle();
        byte_lane_writes();
        contended_round_robin();
        idle_master_isolation();
        random_traffic();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
source/bus_pkg.sv
source/arb_pkg.sv
source/mem_bus_if.sv
source/id_arbiter.sv
source/word_ram.sv
source/mem_subsystem_top.sv
sim/id_arbiter_properties.sv
sim/mem_subsystem_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module mem_subsystem_tb
out=$(./obj_dir/Vmem_subsystem_tb)
echo "$out"

if echo "$out" | grep -q "^SIMULATION PASSED$"; then
    exit 0
fi
exit 1
